/* pipeline_pkg.sv */
package pipeline_pkg;

    typedef logic [31:0] bus32_t;    // PCs, addresses, CSR data
    typedef logic [13:0] csr_addr_t;
    typedef logic [11:0] int_vec_t;  // LIE / IS layout
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // Stage-freeze mask
    // [0] PC, [1] icache, [2] inst buffer, [3] decode
    // [4] dispatch, [5] execute, [6] memory, [7] write-back
    typedef logic [7:0] pause_t;

    // CSR map, reduced set
    localparam csr_addr_t CSR_CRMD   = 14'h0;
    localparam csr_addr_t CSR_PRMD   = 14'h1;
    localparam csr_addr_t CSR_ECFG   = 14'h4;
    localparam csr_addr_t CSR_ESTAT  = 14'h5;
    localparam csr_addr_t CSR_ERA    = 14'h6;
    localparam csr_addr_t CSR_BADV   = 14'h7;
    localparam csr_addr_t CSR_EENTRY = 14'hC;

    typedef enum logic [4:0] {
        EXC_NONE,
        EXC_INT,
        EXC_PIL,
        EXC_PIS,
        EXC_PIF,
        EXC_PME,
        EXC_PPI,
        EXC_ADEF,
        EXC_ADEM,
        EXC_ALE,
        EXC_SYS,
        EXC_BRK,
        EXC_INE,
        EXC_IPE,
        EXC_FPD,
        EXC_FPE,
        EXC_TLBR
    } exc_cause_t;

    // PCs carried by bubbles, never raise an exception
    localparam bus32_t BUBBLE_PC0 = 32'h0000_0000;
    localparam bus32_t BUBBLE_PC1 = 32'h0000_00FC;

    localparam bus32_t CRMD_RESET = 32'h0000_0008;  // DA=1, PLV=0, IE=0

endpackage

/* exc_arbiter.sv */
`timescale 1ns/1ps

module exc_arbiter #(
    parameter int NUM_EXC_SLOTS = 6
) (
    input  logic [NUM_EXC_SLOTS-1:0]                     is_exception_i,
    input  pipeline_pkg::exc_cause_t [NUM_EXC_SLOTS-1:0] exception_cause_i,
    input  pipeline_pkg::bus32_t                         pc_i,
    output logic                                         valid_o,
    output pipeline_pkg::exc_cause_t                     cause_o,
    output pipeline_pkg::ecode_t                         ecode_o,
    output pipeline_pkg::esubcode_t                      esubcode_o
);
    import pipeline_pkg::*;

    logic       is_bubble;
    exc_cause_t sel_cause;

    assign is_bubble = (pc_i == BUBBLE_PC0) || (pc_i == BUBBLE_PC1);
    assign valid_o   = (|is_exception_i) && !is_bubble;

    // Later slots overwrite earlier ones, so the highest index wins
    always_comb begin
        sel_cause = EXC_NONE;
        for (int i = 0; i < NUM_EXC_SLOTS; i++) begin
            if (is_exception_i[i]) begin
                sel_cause = exception_cause_i[i];
            end
        end
    end

    assign cause_o = valid_o ? sel_cause : EXC_NONE;

    always_comb begin
        esubcode_o = '0;
        case (cause_o)
            EXC_INT:  ecode_o = 6'h00;
            EXC_PIL:  ecode_o = 6'h01;
            EXC_PIS:  ecode_o = 6'h02;
            EXC_PIF:  ecode_o = 6'h03;
            EXC_PME:  ecode_o = 6'h04;
            EXC_PPI:  ecode_o = 6'h07;
            EXC_ADEF: ecode_o = 6'h08;
            EXC_ADEM: begin
                ecode_o    = 6'h08;
                esubcode_o = 9'h001;  // ADEM is ADE with subcode 1
            end
            EXC_ALE:  ecode_o = 6'h09;
            EXC_SYS:  ecode_o = 6'h0B;
            EXC_BRK:  ecode_o = 6'h0C;
            EXC_INE:  ecode_o = 6'h0D;
            EXC_IPE:  ecode_o = 6'h0E;
            EXC_FPD:  ecode_o = 6'h0F;
            EXC_FPE:  ecode_o = 6'h12;
            EXC_TLBR: ecode_o = 6'h3F;
            default:  ecode_o = 6'h00;
        endcase
    end

endmodule

/* stall_ctrl.sv */
`timescale 1ns/1ps

module stall_ctrl (
    input  logic                 pause_if_i,
    input  logic                 pause_id_i,
    input  logic                 pause_dispatch_i,
    input  logic                 pause_ex_i,
    input  logic                 pause_mem_i,
    input  logic                 idle_wait_i,
    output pipeline_pkg::pause_t pause_o,
    output logic                 send_inst1_en_o
);

    // Earlier stage requests take priority
    always_comb begin
        if (pause_if_i) begin
            pause_o = 8'h01;                   // PC only
        end else if (pause_id_i) begin
            pause_o = 8'h0F;
        end else if (pause_dispatch_i) begin
            pause_o = 8'h1F;
        end else if (pause_ex_i) begin
            pause_o = 8'h3F;
        end else if (pause_mem_i || idle_wait_i) begin
            pause_o = 8'h7F;                   // Everything but write-back
        end else begin
            pause_o = 8'h00;
        end
    end

    // Instruction buffer frozen, hold dispatch of the second slot
    assign send_inst1_en_o = !pause_o[2];

endmodule

/* ctrl.sv */
`timescale 1ns/1ps

module ctrl #(
    parameter int NUM_EXC_SLOTS = 6
) (
    input  logic [NUM_EXC_SLOTS-1:0]                     mem_is_exception_i,
    input  pipeline_pkg::exc_cause_t [NUM_EXC_SLOTS-1:0] mem_exception_cause_i,
    input  pipeline_pkg::bus32_t                         mem_pc_i,
    input  pipeline_pkg::bus32_t                         mem_exception_addr_i,
    input  logic                                         mem_is_ertn_i,
    input  logic                                         mem_is_idle_i,
    input  logic                                         continue_idle_i,
    input  logic                                         pause_if_i,
    input  logic                                         pause_id_i,
    input  logic                                         pause_dispatch_i,
    input  logic                                         pause_ex_i,
    input  logic                                         pause_mem_i,
    input  pipeline_pkg::bus32_t                         era_i,
    input  pipeline_pkg::bus32_t                         eentry_i,
    input  pipeline_pkg::int_vec_t                       ecfg_lie_i,
    input  pipeline_pkg::int_vec_t                       estat_is_i,
    input  logic                                         crmd_ie_i,
    output logic                                         exception_flush_o,
    output pipeline_pkg::bus32_t                         exception_new_pc_o,
    output logic                                         is_interrupt_o,
    output pipeline_pkg::pause_t                         pause_o,
    output logic                                         send_inst1_en_o,
    output logic                                         exc_commit_o,
    output logic                                         ertn_commit_o,
    output pipeline_pkg::ecode_t                         ecode_o,
    output pipeline_pkg::esubcode_t                      esubcode_o,
    output logic                                         badv_we_o,
    output pipeline_pkg::bus32_t                         badv_o
);
    import pipeline_pkg::*;

    int_vec_t   int_vec;
    logic       exc_valid;
    exc_cause_t exc_cause;
    logic       idle_wait;

    // Enabled and pending lines, masked off globally by IE
    assign int_vec        = crmd_ie_i ? (ecfg_lie_i & estat_is_i) : '0;
    assign is_interrupt_o = |int_vec;

    exc_arbiter #(
        .NUM_EXC_SLOTS(NUM_EXC_SLOTS)
    ) exc_arbiter_inst (
        .is_exception_i   (mem_is_exception_i),
        .exception_cause_i(mem_exception_cause_i),
        .pc_i             (mem_pc_i),
        .valid_o          (exc_valid),
        .cause_o          (exc_cause),
        .ecode_o          (ecode_o),
        .esubcode_o       (esubcode_o)
    );

    assign exception_flush_o  = exc_valid || mem_is_ertn_i;
    assign exception_new_pc_o = mem_is_ertn_i ? era_i : eentry_i;
    assign exc_commit_o       = exc_valid;
    assign ertn_commit_o      = mem_is_ertn_i && !exc_valid;  // Exception takes precedence

    // Address faults record the offending address
    assign badv_we_o = (exc_cause == EXC_ADEF) || (exc_cause == EXC_ADEM) ||
                       (exc_cause == EXC_ALE)  || (exc_cause == EXC_TLBR);
    assign badv_o    = (exc_cause == EXC_ADEF) ? mem_pc_i : mem_exception_addr_i;

    // IDLE holds the pipe until an interrupt arrives
    assign idle_wait = mem_is_idle_i && (int_vec == '0) && !continue_idle_i;

    stall_ctrl stall_ctrl_inst (
        .pause_if_i      (pause_if_i),
        .pause_id_i      (pause_id_i),
        .pause_dispatch_i(pause_dispatch_i),
        .pause_ex_i      (pause_ex_i),
        .pause_mem_i     (pause_mem_i),
        .idle_wait_i     (idle_wait),
        .pause_o         (pause_o),
        .send_inst1_en_o (send_inst1_en_o)
    );

endmodule

/* csr_regs.sv */
`timescale 1ns/1ps

module csr_regs (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic                    csr_we_i,
    input  pipeline_pkg::csr_addr_t csr_waddr_i,
    input  pipeline_pkg::bus32_t    csr_wdata_i,
    input  pipeline_pkg::csr_addr_t csr_raddr_i,
    output pipeline_pkg::bus32_t    csr_rdata_o,
    input  logic [7:0]              hw_int_i,
    input  logic                    exc_commit_i,
    input  logic                    ertn_commit_i,
    input  pipeline_pkg::ecode_t    ecode_i,
    input  pipeline_pkg::esubcode_t esubcode_i,
    input  logic                    badv_we_i,
    input  pipeline_pkg::bus32_t    badv_i,
    input  pipeline_pkg::bus32_t    exc_pc_i,
    output pipeline_pkg::bus32_t    era_o,
    output pipeline_pkg::bus32_t    eentry_o,
    output pipeline_pkg::int_vec_t  ecfg_lie_o,
    output pipeline_pkg::int_vec_t  estat_is_o,
    output logic                    crmd_ie_o
);
    import pipeline_pkg::*;

    // Software-writable bits per CSR
    localparam bus32_t CRMD_WMASK   = 32'h0000_0007;
    localparam bus32_t PRMD_WMASK   = 32'h0000_0007;
    localparam bus32_t ECFG_WMASK   = 32'h0000_1BFF;  // LIE 12:11, 9:0
    localparam bus32_t ESTAT_WMASK  = 32'h0000_0003;  // Software IS only
    localparam bus32_t EENTRY_WMASK = 32'hFFFF_FFC0;

    bus32_t crmd_q, prmd_q, ecfg_q, estat_q, era_q, badv_q, eentry_q;
    bus32_t crmd_cur, prmd_cur, ecfg_cur, estat_cur, era_cur, badv_cur, eentry_cur;
    bus32_t crmd_n, prmd_n, estat_n, era_n, badv_n;

    // Pending write-back write merged over the register under its mask
    function automatic bus32_t merge_wr(input bus32_t q, input bus32_t mask,
                                        input logic hit);
        bus32_t r;
        r = hit ? ((q & ~mask) | (csr_wdata_i & mask)) : q;
        return r;
    endfunction

    assign crmd_cur   = merge_wr(crmd_q, CRMD_WMASK, csr_we_i && csr_waddr_i == CSR_CRMD);
    assign prmd_cur   = merge_wr(prmd_q, PRMD_WMASK, csr_we_i && csr_waddr_i == CSR_PRMD);
    assign ecfg_cur   = merge_wr(ecfg_q, ECFG_WMASK, csr_we_i && csr_waddr_i == CSR_ECFG);
    assign estat_cur  = merge_wr(estat_q, ESTAT_WMASK, csr_we_i && csr_waddr_i == CSR_ESTAT);
    assign era_cur    = merge_wr(era_q, '1, csr_we_i && csr_waddr_i == CSR_ERA);
    assign badv_cur   = merge_wr(badv_q, '1, csr_we_i && csr_waddr_i == CSR_BADV);
    assign eentry_cur = merge_wr(eentry_q, EENTRY_WMASK, csr_we_i && csr_waddr_i == CSR_EENTRY);

    // Commit updates land after the write so they win on shared fields
    always_comb begin
        crmd_n       = crmd_cur;
        prmd_n       = prmd_cur;
        estat_n      = estat_cur;
        era_n        = era_cur;
        badv_n       = badv_cur;
        estat_n[9:2] = hw_int_i;                // Hardware lines sampled every edge
        if (exc_commit_i) begin
            prmd_n[2:0]    = crmd_cur[2:0];     // PIE, PPLV
            crmd_n[2:0]    = 3'b000;
            estat_n[21:16] = ecode_i;
            estat_n[30:22] = esubcode_i;
            era_n          = exc_pc_i;
            if (badv_we_i) begin
                badv_n = badv_i;
            end
        end else if (ertn_commit_i) begin
            crmd_n[2:0] = prmd_cur[2:0];        // Restore IE, PLV
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crmd_q   <= CRMD_RESET;
            prmd_q   <= '0;
            ecfg_q   <= '0;
            estat_q  <= '0;
            era_q    <= '0;
            badv_q   <= '0;
            eentry_q <= '0;
        end else begin
            crmd_q   <= crmd_n;
            prmd_q   <= prmd_n;
            ecfg_q   <= ecfg_cur;
            estat_q  <= estat_n;
            era_q    <= era_n;
            badv_q   <= badv_n;
            eentry_q <= eentry_cur;
        end
    end

    // Read port sees registered state only
    always_comb begin
        case (csr_raddr_i)
            CSR_CRMD:   csr_rdata_o = crmd_q;
            CSR_PRMD:   csr_rdata_o = prmd_q;
            CSR_ECFG:   csr_rdata_o = ecfg_q;
            CSR_ESTAT:  csr_rdata_o = estat_q;
            CSR_ERA:    csr_rdata_o = era_q;
            CSR_BADV:   csr_rdata_o = badv_q;
            CSR_EENTRY: csr_rdata_o = eentry_q;
            default:    csr_rdata_o = '0;
        endcase
    end

    // Current values for the control block
    assign era_o      = era_cur;
    assign eentry_o   = eentry_cur;
    assign ecfg_lie_o = {ecfg_cur[12:11], ecfg_cur[9:0]};
    assign estat_is_o = {estat_cur[12:11], estat_cur[9:0]};  // Timer and IPI stay zero
    assign crmd_ie_o  = crmd_cur[2];

endmodule

/* exc_ctrl_top.sv */
`timescale 1ns/1ps

module exc_ctrl_top #(
    parameter int NUM_EXC_SLOTS = 6
) (
    input  logic                                         clk,
    input  logic                                         rst_n_i,
    input  logic [NUM_EXC_SLOTS-1:0]                     mem_is_exception_i,
    input  pipeline_pkg::exc_cause_t [NUM_EXC_SLOTS-1:0] mem_exception_cause_i,
    input  pipeline_pkg::bus32_t                         mem_pc_i,
    input  pipeline_pkg::bus32_t                         mem_exception_addr_i,
    input  logic                                         mem_is_ertn_i,
    input  logic                                         mem_is_idle_i,
    input  logic                                         continue_idle_i,
    input  logic                                         pause_if_i,
    input  logic                                         pause_id_i,
    input  logic                                         pause_dispatch_i,
    input  logic                                         pause_ex_i,
    input  logic                                         pause_mem_i,
    input  logic                                         csr_we_i,
    input  pipeline_pkg::csr_addr_t                      csr_waddr_i,
    input  pipeline_pkg::bus32_t                         csr_wdata_i,
    input  pipeline_pkg::csr_addr_t                      csr_raddr_i,
    input  logic [7:0]                                   hw_int_i,
    output pipeline_pkg::bus32_t                         csr_rdata_o,
    output logic                                         exception_flush_o,
    output pipeline_pkg::bus32_t                         exception_new_pc_o,
    output logic                                         is_interrupt_o,
    output pipeline_pkg::pause_t                         pause_o,
    output logic                                         send_inst1_en_o
);
    import pipeline_pkg::*;

    bus32_t    era, eentry, badv;
    int_vec_t  ecfg_lie, estat_is;
    logic      crmd_ie;
    logic      exc_commit, ertn_commit, badv_we;
    ecode_t    ecode;
    esubcode_t esubcode;

    ctrl #(
        .NUM_EXC_SLOTS(NUM_EXC_SLOTS)
    ) ctrl_inst (
        .mem_is_exception_i   (mem_is_exception_i),
        .mem_exception_cause_i(mem_exception_cause_i),
        .mem_pc_i             (mem_pc_i),
        .mem_exception_addr_i (mem_exception_addr_i),
        .mem_is_ertn_i        (mem_is_ertn_i),
        .mem_is_idle_i        (mem_is_idle_i),
        .continue_idle_i      (continue_idle_i),
        .pause_if_i           (pause_if_i),
        .pause_id_i           (pause_id_i),
        .pause_dispatch_i     (pause_dispatch_i),
        .pause_ex_i           (pause_ex_i),
        .pause_mem_i          (pause_mem_i),
        .era_i                (era),
        .eentry_i             (eentry),
        .ecfg_lie_i           (ecfg_lie),
        .estat_is_i           (estat_is),
        .crmd_ie_i            (crmd_ie),
        .exception_flush_o    (exception_flush_o),
        .exception_new_pc_o   (exception_new_pc_o),
        .is_interrupt_o       (is_interrupt_o),
        .pause_o              (pause_o),
        .send_inst1_en_o      (send_inst1_en_o),
        .exc_commit_o         (exc_commit),
        .ertn_commit_o        (ertn_commit),
        .ecode_o              (ecode),
        .esubcode_o           (esubcode),
        .badv_we_o            (badv_we),
        .badv_o               (badv)
    );

    csr_regs csr_regs_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .csr_we_i     (csr_we_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_raddr_i  (csr_raddr_i),
        .csr_rdata_o  (csr_rdata_o),
        .hw_int_i     (hw_int_i),
        .exc_commit_i (exc_commit),
        .ertn_commit_i(ertn_commit),
        .ecode_i      (ecode),
        .esubcode_i   (esubcode),
        .badv_we_i    (badv_we),
        .badv_i       (badv),
        .exc_pc_i     (mem_pc_i),   // ERA source
        .era_o        (era),
        .eentry_o     (eentry),
        .ecfg_lie_o   (ecfg_lie),
        .estat_is_o   (estat_is),
        .crmd_ie_o    (crmd_ie)
    );

endmodule

/* tb_exc_ctrl.sv */
`timescale 1ns/1ps

module tb_exc_ctrl;
    import pipeline_pkg::*;

    localparam int NSLOT       = 6;
    // Reset, then the tests in order
    localparam int TEST_CYCLES = 2 + 7 + 72 + 150 + 15 + 88 + 47;

    logic                    clk;
    logic                    rst_n_i;
    logic [NSLOT-1:0]        mem_is_exception_i;
    exc_cause_t [NSLOT-1:0]  mem_exception_cause_i;
    bus32_t                  mem_pc_i, mem_exception_addr_i;
    logic                    mem_is_ertn_i, mem_is_idle_i, continue_idle_i;
    logic                    pause_if_i, pause_id_i, pause_dispatch_i, pause_ex_i, pause_mem_i;
    logic                    csr_we_i;
    csr_addr_t               csr_waddr_i, csr_raddr_i;
    bus32_t                  csr_wdata_i, csr_rdata_o, exception_new_pc_o;
    logic [7:0]              hw_int_i;
    logic                    exception_flush_o, is_interrupt_o, send_inst1_en_o;
    pause_t                  pause_o;

    integer seed;
    bus32_t m_crmd, m_prmd, m_ecfg, m_estat, m_era, m_badv, m_eentry;  // Expected CSR state

    exc_ctrl_top #(.NUM_EXC_SLOTS(NSLOT)) exc_ctrl_top_inst (.*);

    always #4 clk = ~clk;

    initial begin
        #(TEST_CYCLES * 2 * 8);
        $display("Watchdog timeout, the tests did not finish in time");
        $display("Test failed");
        $fatal(1);
    end

    task automatic check_eq(input bus32_t actual, input bus32_t expected, input string name);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs;
        mem_is_exception_i    = '0;
        mem_exception_cause_i = '0;
        mem_pc_i              = 32'h1c00_0000;
        mem_exception_addr_i  = '0;
        mem_is_ertn_i         = 1'b0;
        mem_is_idle_i         = 1'b0;
        continue_idle_i       = 1'b0;
        pause_if_i            = 1'b0;
        pause_id_i            = 1'b0;
        pause_dispatch_i      = 1'b0;
        pause_ex_i            = 1'b0;
        pause_mem_i           = 1'b0;
        csr_we_i              = 1'b0;
        csr_waddr_i           = '0;
        csr_wdata_i           = '0;
    endtask

    function automatic bus32_t write_mask(input csr_addr_t a);
        case (a)
            CSR_CRMD, CSR_PRMD: write_mask = 32'h0000_0007;
            CSR_ECFG:           write_mask = 32'h0000_1BFF;
            CSR_ESTAT:          write_mask = 32'h0000_0003;
            CSR_EENTRY:         write_mask = 32'hFFFF_FFC0;
            default:            write_mask = 32'hFFFF_FFFF;
        endcase
    endfunction

    function automatic ecode_t expected_ecode(input exc_cause_t c);
        case (c)
            EXC_PIL:            expected_ecode = 6'h01;
            EXC_PIS:            expected_ecode = 6'h02;
            EXC_PIF:            expected_ecode = 6'h03;
            EXC_PME:            expected_ecode = 6'h04;
            EXC_PPI:            expected_ecode = 6'h07;
            EXC_ADEF, EXC_ADEM: expected_ecode = 6'h08;
            EXC_ALE:            expected_ecode = 6'h09;
            EXC_SYS:            expected_ecode = 6'h0B;
            EXC_BRK:            expected_ecode = 6'h0C;
            EXC_INE:            expected_ecode = 6'h0D;
            EXC_IPE:            expected_ecode = 6'h0E;
            EXC_FPD:            expected_ecode = 6'h0F;
            EXC_FPE:            expected_ecode = 6'h12;
            EXC_TLBR:           expected_ecode = 6'h3F;
            default:            expected_ecode = 6'h00;
        endcase
    endfunction

    // Apply a write-back write to the expected state
    task automatic model_write(input csr_addr_t a, input bus32_t d);
        bus32_t m;
        m = write_mask(a);
        case (a)
            CSR_CRMD:   m_crmd   = (m_crmd & ~m) | (d & m);
            CSR_PRMD:   m_prmd   = (m_prmd & ~m) | (d & m);
            CSR_ECFG:   m_ecfg   = (m_ecfg & ~m) | (d & m);
            CSR_ESTAT:  m_estat  = (m_estat & ~m) | (d & m);
            CSR_ERA:    m_era    = d;
            CSR_BADV:   m_badv   = d;
            CSR_EENTRY: m_eentry = (m_eentry & ~m) | (d & m);
            default:    ;
        endcase
    endtask

    task automatic model_exception(input exc_cause_t c, input bus32_t pc, input bus32_t addr);
        m_prmd[2:0]    = m_crmd[2:0];
        m_crmd[2:0]    = 3'b000;
        m_estat[21:16] = expected_ecode(c);
        m_estat[30:22] = (c == EXC_ADEM) ? 9'h001 : 9'h000;
        m_era          = pc;
        if (c == EXC_ADEF || c == EXC_ADEM || c == EXC_ALE || c == EXC_TLBR) begin
            m_badv = (c == EXC_ADEF) ? pc : addr;
        end
    endtask

    task automatic write_csr(input csr_addr_t a, input bus32_t d);
        next_cycle();
        csr_we_i    = 1'b1;
        csr_waddr_i = a;
        csr_wdata_i = d;
        next_cycle();
        csr_we_i = 1'b0;
        model_write(a, d);
    endtask

    task automatic check_csr(input csr_addr_t a, input bus32_t expected, input string name);
        next_cycle();
        csr_raddr_i = a;
        #1;
        check_eq(csr_rdata_o, expected, name);
    endtask

    task automatic check_all_csrs;
        check_csr(CSR_CRMD, m_crmd, "CRMD");
        check_csr(CSR_PRMD, m_prmd, "PRMD");
        check_csr(CSR_ECFG, m_ecfg, "ECFG");
        check_csr(CSR_ESTAT, m_estat, "ESTAT");
        check_csr(CSR_ERA, m_era, "ERA");
        check_csr(CSR_BADV, m_badv, "BADV");
        check_csr(CSR_EENTRY, m_eentry, "EENTRY");
    endtask

    task automatic test_reset_state;
        check_all_csrs();
        check_eq(exception_flush_o, 0, "exception_flush_o");
        check_eq(is_interrupt_o, 0, "is_interrupt_o");
        check_eq(pause_o, 0, "pause_o");
        check_eq(send_inst1_en_o, 1, "send_inst1_en_o");
    endtask

    task automatic test_write_masks;
        csr_addr_t addrs[7];
        bus32_t    d;
        addrs = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_BADV, CSR_EENTRY};
        for (int i = 0; i < 7; i++) begin
            d = $random(seed);
            write_csr(addrs[i], d);
            check_all_csrs();
        end
        // EENTRY write in the same cycle as an exception is forwarded
        next_cycle();
        d = $random(seed);
        csr_we_i                 = 1'b1;
        csr_waddr_i              = CSR_EENTRY;
        csr_wdata_i              = d;
        mem_is_exception_i       = 6'b000001;
        mem_exception_cause_i[0] = EXC_SYS;
        mem_pc_i                 = 32'h1c00_1000;
        #1;
        check_eq(exception_flush_o, 1, "exception_flush_o");
        check_eq(exception_new_pc_o, d & 32'hFFFF_FFC0, "exception_new_pc_o");
        next_cycle();
        idle_inputs();
        model_write(CSR_EENTRY, d);
        model_exception(EXC_SYS, 32'h1c00_1000, 32'h0);
        check_all_csrs();
    endtask

    task automatic test_exception_record;
        bus32_t     r, pc, addr, tmp;
        exc_cause_t sel;
        for (int n = 0; n < 12; n++) begin
            write_csr(CSR_CRMD, $random(seed));
            next_cycle();
            r  = $random(seed);
            pc = (r & 32'hFFFF_FFFC) | 32'h0000_1000;
            addr = $random(seed);
            mem_is_exception_i = r[5:0] | 6'b000001;
            for (int i = 0; i < NSLOT; i++) begin
                tmp = $random(seed);
                tmp = tmp % 32'd17;
                mem_exception_cause_i[i] = exc_cause_t'(tmp[4:0]);
            end
            mem_pc_i             = pc;
            mem_exception_addr_i = addr;
            sel = EXC_NONE;
            for (int i = 0; i < NSLOT; i++) begin
                if (mem_is_exception_i[i]) begin
                    sel = mem_exception_cause_i[i];
                end
            end
            #1;
            check_eq(exception_flush_o, 1, "exception_flush_o");
            check_eq(exception_new_pc_o, m_eentry, "exception_new_pc_o");
            next_cycle();
            idle_inputs();
            model_exception(sel, pc, addr);
            check_all_csrs();
        end
        // Bubble PCs are ignored
        for (int b = 0; b < 2; b++) begin
            next_cycle();
            mem_is_exception_i       = 6'b100000;
            mem_exception_cause_i[5] = EXC_ALE;
            mem_pc_i                 = (b == 0) ? 32'h0000_00FC : 32'h0;
            #1;
            check_eq(exception_flush_o, 0, "exception_flush_o");
            next_cycle();
            idle_inputs();
            check_all_csrs();
        end
    endtask

    task automatic test_ertn;
        bus32_t era;
        era = $random(seed);
        write_csr(CSR_ERA, era);
        write_csr(CSR_PRMD, 32'h0000_0005);
        write_csr(CSR_CRMD, 32'h0000_0000);
        next_cycle();
        mem_is_ertn_i = 1'b1;
        #1;
        check_eq(exception_flush_o, 1, "exception_flush_o");
        check_eq(exception_new_pc_o, era, "exception_new_pc_o");
        next_cycle();
        mem_is_ertn_i = 1'b0;
        m_crmd[2:0] = m_prmd[2:0];
        check_all_csrs();
    endtask

    task automatic test_interrupts;
        bus32_t   lie, sw, hw;
        int_vec_t is_vec, lie_vec;
        write_csr(CSR_ECFG, 32'h0000_03FC);     // Hardware lines only
        write_csr(CSR_CRMD, 32'h0000_0004);
        next_cycle();
        hw_int_i = 8'h10;
        #1;
        check_eq(is_interrupt_o, 0, "is_interrupt_o");
        next_cycle();
        check_eq(is_interrupt_o, 1, "is_interrupt_o");
        for (int n = 0; n < 10; n++) begin
            lie = $random(seed);
            sw  = $random(seed);
            hw  = $random(seed);
            hw_int_i = hw[7:0];
            write_csr(CSR_ECFG, lie);
            write_csr(CSR_ESTAT, sw);
            write_csr(CSR_CRMD, 32'h0000_0004);
            lie_vec = {lie[12:11], lie[9:0]};
            is_vec  = {2'b00, hw[7:0], sw[1:0]};
            check_eq(is_interrupt_o, |(lie_vec & is_vec), "is_interrupt_o");
            write_csr(CSR_CRMD, 32'h0000_0000);
            check_eq(is_interrupt_o, 0, "is_interrupt_o");
        end
        hw_int_i = 8'h00;
        write_csr(CSR_ESTAT, 32'h0);
    endtask

    task automatic test_pause_idle;
        bus32_t r;
        pause_t exp;
        for (int n = 0; n < 40; n++) begin
            next_cycle();
            r = (n < 5) ? (32'h1 << n) : $random(seed);
            pause_if_i       = r[0];
            pause_id_i       = r[1];
            pause_dispatch_i = r[2];
            pause_ex_i       = r[3];
            pause_mem_i      = r[4];
            if (r[0])      exp = 8'h01;
            else if (r[1]) exp = 8'h0F;
            else if (r[2]) exp = 8'h1F;
            else if (r[3]) exp = 8'h3F;
            else if (r[4]) exp = 8'h7F;
            else           exp = 8'h00;
            #1;
            check_eq(pause_o, exp, "pause_o");
            check_eq(send_inst1_en_o, !exp[2], "send_inst1_en_o");
        end
        next_cycle();
        idle_inputs();
        mem_is_idle_i = 1'b1;
        #1;
        check_eq(pause_o, 8'h7F, "pause_o");
        continue_idle_i = 1'b1;
        #1;
        check_eq(pause_o, 8'h00, "pause_o");
        continue_idle_i = 1'b0;
        write_csr(CSR_ECFG, 32'h0000_0001);
        write_csr(CSR_ESTAT, 32'h0000_0001);
        write_csr(CSR_CRMD, 32'h0000_0004);     // Interrupt now pending
        check_eq(pause_o, 8'h00, "pause_o");
        mem_is_idle_i = 1'b0;
    endtask

    initial begin
        seed     = 32'ha083;
        clk      = 1'b0;
        rst_n_i  = 1'b0;
        hw_int_i = 8'h00;
        csr_raddr_i = '0;
        idle_inputs();
        m_crmd = CRMD_RESET;
        m_prmd = '0;
        m_ecfg = '0;
        m_estat = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        test_reset_state();
        test_write_masks();
        test_exception_record();
        test_ertn();
        test_interrupts();
        test_pause_idle();
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* build.f */
pipeline_pkg.sv
exc_arbiter.sv
stall_ctrl.sv
ctrl.sv
csr_regs.sv
exc_ctrl_top.sv
tb_exc_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; a $fatal gives a failing status
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f build.f --top-module tb_exc_ctrl -o sim_exc_ctrl

./obj_dir/sim_exc_ctrl
